//--- compile.f
rip_const.sv
rip_axi_types.sv
rip_mem_port_if.sv
rip_mmu_read_engine.sv
rip_mmu_write_engine.sv
rip_memory_management_unit.sv
rip_pseudo_core_mmu.sv
tb_axi_mem.sv
tb_pseudo_core_assert.sv
tb_pseudo_core.sv

//--- rip_axi_types.sv
// AXI response codes and memory unit operations.
package rip_axi_types;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_t;

    // Request decoded by the port controller.
    typedef enum logic [1:0] {
        NONE,
        LOAD,
        STORE
    } mmu_op_t;

endpackage

//--- rip_const.sv
// Core-side constants and enums shared by the pseudo core and its memory port.
package rip_const;

    // Width of one byte lane.
    localparam int B_WIDTH = 8;

    // Walk state machine of the pseudo core.
    typedef enum logic [2:0] {
        SLEEP,
        INIT,
        READ,
        READWAIT,
        WRITE,
        WRITEWAIT
    } core_state_t;

    // Phase code driven on the busy output.
    typedef enum logic [1:0] {
        IDLE    = 2'b00, // Waiting for a base address.
        ARMED   = 2'b01, // Base seen once, confirming.
        READING = 2'b10,
        WRITING = 2'b11
    } busy_code_t;

endpackage

//--- rip_mem_port_if.sv
`timescale 1ns/1ps

// Request/response port between the core and the memory unit.
interface rip_mem_port_if import rip_const::*; #(
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 32
);
    logic [DATA_WIDTH/B_WIDTH-1:0] we; // Byte strobes.
    logic                          re;
    logic [ADDR_WIDTH-1:0]         addr;
    logic [DATA_WIDTH-1:0]         din;
    logic [DATA_WIDTH-1:0]         dout; // Held until the next load.
    logic                          busy;
    logic                          err;

    modport core (output we, output re, output addr, output din,
                  input dout, input busy, input err);

    modport mmu (input we, input re, input addr, input din,
                 output dout, output busy, output err);

endinterface

//--- rip_memory_management_unit.sv
`timescale 1ns/1ps

// Port controller: accepts one request, runs one engine, returns the result.
module rip_memory_management_unit import rip_const::*, rip_axi_types::*; #(
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 32
) (
    input  logic                          clk,
    input  logic                          rstn,
    rip_mem_port_if.mmu                   port,
    output logic [ADDR_WIDTH-1:0]         araddr,
    output logic                          arvalid,
    input  logic                          arready,
    input  logic [DATA_WIDTH-1:0]         rdata,
    input  axi_resp_t                     rresp,
    input  logic                          rvalid,
    output logic                          rready,
    output logic [ADDR_WIDTH-1:0]         awaddr,
    output logic                          awvalid,
    input  logic                          awready,
    output logic [DATA_WIDTH-1:0]         wdata,
    output logic [DATA_WIDTH/B_WIDTH-1:0] wstrb,
    output logic                          wvalid,
    input  logic                          wready,
    input  axi_resp_t                     bresp,
    input  logic                          bvalid,
    output logic                          bready
);
    mmu_op_t                       op_req;
    mmu_op_t                       op_r;
    logic                          busy_r;
    logic                          rd_start, wr_start;
    logic [ADDR_WIDTH-1:0]         addr_r;
    logic [DATA_WIDTH-1:0]         din_r;
    logic [DATA_WIDTH/B_WIDTH-1:0] strb_r;
    logic                          rd_done, rd_err, wr_done, wr_err;
    logic [DATA_WIDTH-1:0]         rd_rdata;
    logic                          op_done;

    // Read wins over write.
    always_comb begin
        if (port.re) op_req = LOAD;
        else if (|port.we) op_req = STORE;
        else op_req = NONE;
    end

    assign op_done   = (op_r == LOAD) ? rd_done : wr_done;
    assign port.busy = busy_r;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy_r   <= 1'b0;
            op_r     <= NONE;
            rd_start <= 1'b0;
            wr_start <= 1'b0;
            port.err <= 1'b0;
        end else begin
            rd_start <= 1'b0;
            wr_start <= 1'b0;
            if (!busy_r && op_req != NONE) begin
                busy_r   <= 1'b1;
                op_r     <= op_req;
                rd_start <= (op_req == LOAD);
                wr_start <= (op_req == STORE);
            end else if (busy_r && op_done) begin
                busy_r   <= 1'b0;
                op_r     <= NONE;
                port.err <= (op_r == LOAD) ? rd_err : wr_err;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy_r && op_req != NONE) begin
            addr_r <= port.addr;
            din_r  <= port.din;
            strb_r <= port.we;
        end
        if (busy_r && op_r == LOAD && rd_done) port.dout <= rd_rdata;
    end

    rip_mmu_read_engine #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .DATA_WIDTH(DATA_WIDTH)
    ) u_read (
        .clk(clk), .rstn(rstn), .start(rd_start), .addr(addr_r),
        .done(rd_done), .rdata(rd_rdata), .err(rd_err),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata_axi(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
    );

    rip_mmu_write_engine #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .DATA_WIDTH(DATA_WIDTH)
    ) u_write (
        .clk(clk), .rstn(rstn), .start(wr_start), .addr(addr_r),
        .wdata(din_r), .strb(strb_r), .done(wr_done), .err(wr_err),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata_axi(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready)
    );

endmodule

//--- rip_mmu_read_engine.sv
`timescale 1ns/1ps

// Single AXI read: address phase, then data phase.
module rip_mmu_read_engine import rip_axi_types::*; #(
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  start,
    input  logic [ADDR_WIDTH-1:0] addr,
    output logic                  done,
    output logic [DATA_WIDTH-1:0] rdata,
    output logic                  err,
    output logic [ADDR_WIDTH-1:0] araddr,
    output logic                  arvalid,
    input  logic                  arready,
    input  logic [DATA_WIDTH-1:0] rdata_axi,
    input  axi_resp_t             rresp,
    input  logic                  rvalid,
    output logic                  rready
);
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_t;

    rd_state_t state;

    assign arvalid = (state == RD_ADDR);
    assign rready  = (state == RD_DATA);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= RD_IDLE;
            done  <= 1'b0;
            err   <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                RD_IDLE: if (start) state <= RD_ADDR;
                RD_ADDR: if (arready) state <= RD_DATA;
                RD_DATA: begin
                    if (rvalid) begin
                        state <= RD_IDLE;
                        done  <= 1'b1;
                        err   <= (rresp != OKAY);
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RD_IDLE && start) araddr <= addr; // Stable through the address phase.
        if (state == RD_DATA && rvalid) rdata <= rdata_axi;
    end

endmodule

//--- rip_mmu_write_engine.sv
`timescale 1ns/1ps

// Single AXI write: address and data in any order, then the response.
module rip_mmu_write_engine import rip_const::*, rip_axi_types::*; #(
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 32
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          start,
    input  logic [ADDR_WIDTH-1:0]         addr,
    input  logic [DATA_WIDTH-1:0]         wdata,
    input  logic [DATA_WIDTH/B_WIDTH-1:0] strb,
    output logic                          done,
    output logic                          err,
    output logic [ADDR_WIDTH-1:0]         awaddr,
    output logic                          awvalid,
    input  logic                          awready,
    output logic [DATA_WIDTH-1:0]         wdata_axi,
    output logic [DATA_WIDTH/B_WIDTH-1:0] wstrb,
    output logic                          wvalid,
    input  logic                          wready,
    input  axi_resp_t                     bresp,
    input  logic                          bvalid,
    output logic                          bready
);
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_REQ,
        WR_RESP
    } wr_state_t;

    wr_state_t state;
    logic      aw_done;
    logic      w_done;
    logic      aw_ok;
    logic      w_ok;

    assign awvalid = (state == WR_REQ) && !aw_done;
    assign wvalid  = (state == WR_REQ) && !w_done;
    assign bready  = (state == WR_RESP);

    // Handshake finished earlier or on this edge.
    assign aw_ok = aw_done || (awvalid && awready);
    assign w_ok  = w_done || (wvalid && wready);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= WR_IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            done    <= 1'b0;
            err     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                WR_IDLE: begin
                    aw_done <= 1'b0;
                    w_done  <= 1'b0;
                    if (start) state <= WR_REQ;
                end
                WR_REQ: begin
                    aw_done <= aw_ok;
                    w_done  <= w_ok;
                    if (aw_ok && w_ok) state <= WR_RESP;
                end
                WR_RESP: begin
                    if (bvalid) begin
                        state <= WR_IDLE;
                        done  <= 1'b1;
                        err   <= (bresp != OKAY);
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == WR_IDLE && start) begin
            awaddr    <= addr;
            wdata_axi <= wdata;
            wstrb     <= strb;
        end
    end

endmodule

//--- rip_pseudo_core_mmu.sv
`timescale 1ns/1ps

// Pseudo core that reads and writes back a window of memory for board test.
module rip_pseudo_core_mmu import rip_const::*, rip_axi_types::*; #(
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 32,
    parameter int DATA_LEN   = 256
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic [ADDR_WIDTH-1:0]         mem_head,
    output logic [1:0]                    busy,
    output logic [ADDR_WIDTH-1:0]         araddr,
    output logic                          arvalid,
    input  logic                          arready,
    input  logic [DATA_WIDTH-1:0]         rdata,
    input  axi_resp_t                     rresp,
    input  logic                          rvalid,
    output logic                          rready,
    output logic [ADDR_WIDTH-1:0]         awaddr,
    output logic                          awvalid,
    input  logic                          awready,
    output logic [DATA_WIDTH-1:0]         wdata,
    output logic [DATA_WIDTH/B_WIDTH-1:0] wstrb,
    output logic                          wvalid,
    input  logic                          wready,
    input  axi_resp_t                     bresp,
    input  logic                          bvalid,
    output logic                          bready
);
    core_state_t           state;
    busy_code_t            busy_code;
    logic [ADDR_WIDTH-1:0] mem_offset; // Base of the walk.
    logic [ADDR_WIDTH-1:0] cnt;
    logic [ADDR_WIDTH-1:0] word_addr;

    rip_mem_port_if #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .DATA_WIDTH(DATA_WIDTH)
    ) mem_port ();

    rip_memory_management_unit #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .DATA_WIDTH(DATA_WIDTH)
    ) mmu (
        .clk(clk), .rstn(rstn), .port(mem_port.mmu),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready)
    );

    assign word_addr = mem_offset | (cnt << 2);

    always_comb begin
        case (state)
            SLEEP:            busy_code = IDLE;
            READ, READWAIT:   busy_code = READING;
            WRITE, WRITEWAIT: busy_code = WRITING;
            default:          busy_code = ARMED;
        endcase
    end

    assign busy = busy_code;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state       <= SLEEP;
            mem_offset  <= '0;
            cnt         <= '0;
            mem_port.re <= 1'b0;
            mem_port.we <= '0;
        end else begin
            case (state)
                SLEEP: begin
                    if (mem_head != '1) begin // All ones means no work.
                        mem_offset <= mem_head;
                        cnt        <= '0;
                        state      <= INIT;
                    end
                end
                INIT: begin
                    // Start only on a value seen twice in a row.
                    if (mem_head == mem_offset) begin
                        mem_port.addr <= word_addr;
                        mem_port.re   <= 1'b1;
                        state         <= READ;
                    end else begin
                        state <= SLEEP;
                    end
                end
                READ: begin
                    if (!mem_port.busy) begin // Accepted on this edge.
                        mem_port.re <= 1'b0;
                        state       <= READWAIT;
                    end
                end
                READWAIT: begin
                    if (!mem_port.busy) begin
                        mem_port.din <= mem_port.dout;
                        mem_port.we  <= '1;
                        state        <= WRITE;
                    end
                end
                WRITE: begin
                    if (!mem_port.busy) begin
                        mem_port.we <= '0;
                        cnt         <= cnt + 1'b1;
                        state       <= WRITEWAIT;
                    end
                end
                WRITEWAIT: begin
                    if (!mem_port.busy) begin
                        if (cnt < DATA_LEN) begin
                            mem_port.addr <= word_addr;
                            mem_port.re   <= 1'b1;
                            state         <= READ;
                        end else begin
                            state <= SLEEP;
                        end
                    end
                end
                default: state <= SLEEP;
            endcase
        end
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator; pass/fail from the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f \
    --top-module tb_pseudo_core -o sim_pseudo_core \
    && ./obj_dir/sim_pseudo_core > sim.log 2>&1
cat sim.log 2>/dev/null

grep -q "All checks passed" sim.log 2>/dev/null \
    && echo "RESULT: PASS" \
    || { echo "RESULT: FAIL"; exit 1; }

//--- tb_axi_mem.sv
`timescale 1ns/1ps

// AXI slave memory with random handshake delays and a log of transfers.
module tb_axi_mem import rip_axi_types::*; #(
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 32,
    parameter int IDX_W      = 10
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic [ADDR_WIDTH-1:0]         araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output logic [DATA_WIDTH-1:0]         rdata,
    output axi_resp_t                     rresp,
    output logic                          rvalid,
    input  logic                          rready,
    input  logic [ADDR_WIDTH-1:0]         awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [DATA_WIDTH-1:0]         wdata,
    input  logic [DATA_WIDTH/8-1:0]       wstrb,
    input  logic                          wvalid,
    output logic                          wready,
    output axi_resp_t                     bresp,
    output logic                          bvalid,
    input  logic                          bready
);
    localparam int MEM_WORDS = 1 << IDX_W;

    logic [DATA_WIDTH-1:0]   mem [MEM_WORDS];
    bit                      log_write [$]; // 0 read, 1 write.
    logic [ADDR_WIDTH-1:0]   log_addr [$];
    logic [DATA_WIDTH-1:0]   log_data [$];
    logic [DATA_WIDTH/8-1:0] log_strb [$];

    logic                    rd_pend;
    logic [ADDR_WIDTH-1:0]   rd_a;
    int                      rd_wait;
    logic                    aw_got;
    logic                    w_got;
    logic [ADDR_WIDTH-1:0]   aw_a;
    logic [DATA_WIDTH-1:0]   w_d;
    logic [DATA_WIDTH/8-1:0] w_s;
    int                      b_wait;

    // Random contents mixed with the full word index.
    task automatic fill_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = $urandom() ^ (i * 32'h9e37_79b9) ^ (i << 20);
        end
    endtask

    always @(posedge clk) begin
        if (!rstn) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            rresp   <= OKAY;
            rd_pend <= 1'b0;
            rd_wait <= 0;
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= OKAY;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            b_wait  <= 0;
        end else begin
            if (arvalid && arready) begin
                rd_pend <= 1'b1;
                rd_a    <= araddr;
                rd_wait <= $urandom_range(0, 3);
                arready <= 1'b0;
                log_write.push_back(1'b0);
                log_addr.push_back(araddr);
                log_data.push_back('0);
                log_strb.push_back('0);
            end else if (!rd_pend) begin
                arready <= ($urandom_range(0, 3) != 0);
            end
            if (rd_pend && !rvalid) begin
                if (rd_wait == 0) begin
                    rvalid <= 1'b1;
                    rdata  <= mem[rd_a[IDX_W+1:2]];
                end else begin
                    rd_wait <= rd_wait - 1;
                end
            end
            if (rvalid && rready) begin
                rvalid  <= 1'b0;
                rd_pend <= 1'b0;
            end

            if (awvalid && awready) begin
                aw_got  <= 1'b1;
                aw_a    <= awaddr;
                awready <= 1'b0;
                b_wait  <= $urandom_range(0, 3);
            end else if (!aw_got) begin
                awready <= ($urandom_range(0, 2) != 0);
            end
            if (wvalid && wready) begin
                w_got  <= 1'b1;
                w_d    <= wdata;
                w_s    <= wstrb;
                wready <= 1'b0;
            end else if (!w_got) begin
                wready <= ($urandom_range(0, 2) != 0);
            end
            if (aw_got && w_got && !bvalid) begin
                if (b_wait == 0) begin
                    bvalid <= 1'b1;
                    bresp  <= OKAY;
                    for (int b = 0; b < DATA_WIDTH / 8; b++) begin
                        if (w_s[b]) mem[aw_a[IDX_W+1:2]][b*8 +: 8] = w_d[b*8 +: 8];
                    end
                    log_write.push_back(1'b1);
                    log_addr.push_back(aw_a);
                    log_data.push_back(w_d);
                    log_strb.push_back(w_s);
                end else begin
                    b_wait <= b_wait - 1;
                end
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                aw_got <= 1'b0;
                w_got  <= 1'b0;
            end
        end
    end

endmodule

//--- tb_pseudo_core.sv
`timescale 1ns/1ps

module tb_pseudo_core import rip_const::*, rip_axi_types::*;;
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int DATA_LEN   = 16;
    localparam int IDX_W      = 10;
    localparam int MEM_WORDS  = 1 << IDX_W;
    localparam int NUM_WALKS  = 5; // Four random walks plus one after the aborted start.
    localparam int TIMEOUT_NS = NUM_WALKS * DATA_LEN * 200 * 10 + 20000;

    logic                    clk = 1'b0;
    logic                    rstn;
    logic [ADDR_WIDTH-1:0]   mem_head;
    logic [1:0]              busy;
    logic [ADDR_WIDTH-1:0]   araddr, awaddr;
    logic                    arvalid, arready, rvalid, rready;
    logic                    awvalid, awready, wvalid, wready, bvalid, bready;
    logic [DATA_WIDTH-1:0]   rdata, wdata;
    logic [DATA_WIDTH/8-1:0] wstrb;
    axi_resp_t               rresp, bresp;

    logic [DATA_WIDTH-1:0]   mem_before [MEM_WORDS];
    bit                      exp_write [$];
    logic [ADDR_WIDTH-1:0]   exp_addr [$];
    logic [DATA_WIDTH-1:0]   exp_data [$];
    logic [DATA_WIDTH/8-1:0] exp_strb [$];
    bit                      expect_idle = 1'b0;

    always #5 clk = ~clk;

    rip_pseudo_core_mmu #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .DATA_WIDTH(DATA_WIDTH),
        .DATA_LEN(DATA_LEN)
    ) dut (.*);

    tb_axi_mem #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .DATA_WIDTH(DATA_WIDTH),
        .IDX_W(IDX_W)
    ) mem_model (.*);

    bind rip_memory_management_unit tb_pseudo_core_assert #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .DATA_WIDTH(DATA_WIDTH)
    ) u_assert (.*, .err(port.err));

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "stopped at %0t", $time);
    endtask

    // Expected transfers of one walk: read, then write-back of the old word.
    function automatic void build_expected(input logic [ADDR_WIDTH-1:0] base);
        logic [ADDR_WIDTH-1:0] a;
        for (int i = 0; i < DATA_LEN; i++) begin
            a = base | (ADDR_WIDTH'(i) << 2);
            exp_write.push_back(1'b0);
            exp_addr.push_back(a);
            exp_data.push_back('0);
            exp_strb.push_back('0);
            exp_write.push_back(1'b1);
            exp_addr.push_back(a);
            exp_data.push_back(mem_before[a[IDX_W+1:2]]);
            exp_strb.push_back('1);
        end
    endfunction

    // Compare logged transfers on the falling edge.
    always @(negedge clk) begin
        bit                      g_w;
        logic [ADDR_WIDTH-1:0]   g_a;
        logic [DATA_WIDTH-1:0]   g_d;
        logic [DATA_WIDTH/8-1:0] g_s;
        while (mem_model.log_addr.size() > 0) begin
            g_w = mem_model.log_write.pop_front();
            g_a = mem_model.log_addr.pop_front();
            g_d = mem_model.log_data.pop_front();
            g_s = mem_model.log_strb.pop_front();
            assert (exp_addr.size() > 0)
                else stop_on_error($sformatf("Unexpected AXI transfer at %0h", g_a));
            assert (g_w == exp_write[0])
                else stop_on_error($sformatf("MISMATCH %0t kind exp %0d got %0d",
                                             $time, exp_write[0], g_w));
            assert (g_a == exp_addr[0])
                else stop_on_error($sformatf("MISMATCH %0t addr exp %h got %h",
                                             $time, exp_addr[0], g_a));
            assert (g_d == exp_data[0])
                else stop_on_error($sformatf("MISMATCH %0t wdata exp %h got %h",
                                             $time, exp_data[0], g_d));
            assert (g_s == exp_strb[0])
                else stop_on_error($sformatf("MISMATCH %0t wstrb exp %h got %h",
                                             $time, exp_strb[0], g_s));
            void'(exp_write.pop_front());
            void'(exp_addr.pop_front());
            void'(exp_data.pop_front());
            void'(exp_strb.pop_front());
        end
    end

    // Busy phase against bus activity.
    always @(negedge clk) begin
        if (rstn) begin
            if (arvalid || rready)
                assert (busy == READING)
                    else stop_on_error($sformatf("MISMATCH %0t busy exp %b got %b",
                                                 $time, READING, busy));
            if (awvalid || wvalid || bready)
                assert (busy == WRITING)
                    else stop_on_error($sformatf("MISMATCH %0t busy exp %b got %b",
                                                 $time, WRITING, busy));
            if (expect_idle) begin
                assert (busy == IDLE)
                    else stop_on_error($sformatf("MISMATCH %0t busy exp %b got %b",
                                                 $time, IDLE, busy));
                assert (!arvalid && !awvalid)
                    else stop_on_error("AXI request seen while the core should be idle");
            end
        end
    end

    task automatic idle_window(input int cycles);
        expect_idle = 1'b1;
        repeat (cycles) @(posedge clk);
        expect_idle = 1'b0;
    endtask

    task automatic run_walk(input logic [ADDR_WIDTH-1:0] base);
        for (int i = 0; i < MEM_WORDS; i++) mem_before[i] = mem_model.mem[i];
        build_expected(base);
        @(posedge clk);
        mem_head <= base;
        @(posedge clk);
        @(negedge clk);
        assert (busy == ARMED) // First look at the new base.
            else stop_on_error($sformatf("MISMATCH %0t busy exp %b got %b",
                                         $time, ARMED, busy));
        repeat (2) @(posedge clk);
        @(negedge clk);
        assert (!arvalid) else stop_on_error("arvalid rose too early");
        @(posedge clk);
        @(negedge clk);
        assert (arvalid)
            else stop_on_error($sformatf("MISMATCH %0t arvalid exp 1 got %b", $time, arvalid));
        @(posedge clk);
        mem_head <= '1; // Stops a second walk.
        while (exp_addr.size() > 0 || busy != IDLE) @(posedge clk);
        idle_window(10);
        for (int i = 0; i < MEM_WORDS; i++) begin
            assert (mem_model.mem[i] == mem_before[i])
                else stop_on_error($sformatf("MISMATCH %0t mem[%0d] exp %h got %h",
                                             $time, i, mem_before[i], mem_model.mem[i]));
        end
    endtask

    initial begin
        logic [ADDR_WIDTH-1:0] base;
        void'($urandom(32'hc4fa));
        rstn     = 1'b0;
        mem_head = '1;
        mem_model.fill_memory();
        repeat (10) @(posedge clk);
        rstn <= 1'b1;
        idle_window(20);

        for (int w = 0; w < NUM_WALKS - 1; w++) begin
            base = ADDR_WIDTH'($urandom_range(0, MEM_WORDS - 1)) << 2;
            run_walk(base);
        end

        // Base changes during INIT.
        @(posedge clk);
        mem_head <= 32'h0000_0100;
        @(posedge clk);
        mem_head <= 32'h0000_0200;
        @(posedge clk);
        mem_head <= '1;
        repeat (2) @(posedge clk);
        idle_window(30);
        run_walk(32'h0000_0240);

        $display("All checks passed");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired before all walks finished");
        $display("Checks failed");
        $fatal(1, "timeout");
    end

endmodule

//--- tb_pseudo_core_assert.sv
`timescale 1ns/1ps

// AXI protocol and port checks, bound into the memory unit.
module tb_pseudo_core_assert #(
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 32
) (
    input logic                    clk,
    input logic                    rstn,
    input logic [ADDR_WIDTH-1:0]   araddr,
    input logic                    arvalid,
    input logic                    arready,
    input logic                    rvalid,
    input logic                    rready,
    input logic [ADDR_WIDTH-1:0]   awaddr,
    input logic                    awvalid,
    input logic                    awready,
    input logic [DATA_WIDTH-1:0]   wdata,
    input logic [DATA_WIDTH/8-1:0] wstrb,
    input logic                    wvalid,
    input logic                    wready,
    input logic                    bvalid,
    input logic                    bready,
    input logic                    busy_r,
    input logic                    err
);
    a_valid_hold: assert property (@(posedge clk) disable iff (!rstn)
        (arvalid && !arready |=> arvalid) and (awvalid && !awready |=> awvalid)
        and (wvalid && !wready |=> wvalid))
        else $error("valid dropped before ready");

    a_payload_stable: assert property (@(posedge clk) disable iff (!rstn)
        (arvalid && !arready |=> $stable(araddr)) and (awvalid && !awready |=> $stable(awaddr))
        and (wvalid && !wready |=> $stable(wdata) && $stable(wstrb)))
        else $error("payload changed while waiting for ready");

    // Engine done one cycle after the last handshake, busy one cycle later.
    a_busy_hold: assert property (@(posedge clk) disable iff (!rstn)
        $fell(busy_r) |-> $past((rvalid && rready) || (bvalid && bready), 2) && !err)
        else $error("port busy fell without a finished OKAY transfer");

    a_one_outstanding: assert property (@(posedge clk) disable iff (!rstn)
        !((arvalid || rready) && (awvalid || wvalid || bready)))
        else $error("read and write in flight together");

endmodule
